/* bench/xm_top_tb.sv */
`include "riscv_defs.svh"

module xm_top_tb;

    localparam int RESET_CYCLES = 5;
    localparam int NUM_DIRECTED = 64;
    localparam int NUM_RANDOM = 200;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_DIRECTED + NUM_RANDOM + 40;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  inst_valid;
    logic [`XLEN-1:0]      inst;
    logic [`XLEN-1:0]      pc_xm;
    logic [`XLEN-1:0]      rs1_data;
    logic [`XLEN-1:0]      rs2_data;
    logic                  out_valid;
    riscv_pkg::xm_result_t result;
    logic [`XLEN-1:0]      cycle_count;
    logic [`XLEN-1:0]      inst_count;

    // reference pipeline state, one register stage like the DUT.
    logic                  checking = 1'b0;
    logic                  exp_valid;
    riscv_pkg::xm_result_t exp_result;
    logic [`XLEN-1:0]      exp_cycle;
    logic [`XLEN-1:0]      exp_inst;
    integer                seed = 32'h0a17c6fc;
    int                    issued = 0;

    xm_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc_xm      (pc_xm),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .out_valid  (out_valid),
        .result     (result),
        .cycle_count(cycle_count),
        .inst_count (inst_count)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, `OPC_OP};
    endfunction

    function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [2:0] f3,
                                             input logic [4:0] rs1, input logic [6:0] opc);
        return {imm, rs1, f3, 5'd3, opc};
    endfunction

    function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], `OPC_STORE};
    endfunction

    function automatic logic [31:0] b_format(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_format(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd3, `OPC_JAL};
    endfunction

    // op is funct7 bit 5 followed by funct3; 1110 and 1111 are the two pass-through ops.
    function automatic logic [31:0] alu_model(input logic [3:0] op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            4'b0000: return a + b;
            4'b1000: return a - b;
            4'b0001: return a << b[4:0];
            4'b0010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4'b0011: return (a < b) ? 32'd1 : 32'd0;
            4'b0100: return a ^ b;
            4'b0101: return a >> b[4:0];
            4'b1101: return $signed(a) >>> b[4:0];
            4'b0110: return a | b;
            4'b0111: return a & b;
            4'b1111: return a;
            default: return b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic riscv_pkg::xm_result_t expect_result(input logic valid,
        input logic [31:0] word, input logic [31:0] pc, input logic [31:0] a,
        input logic [31:0] b);
        riscv_pkg::xm_result_t r;
        logic [6:0]            opc;
        logic [2:0]            f3;
        logic [31:0]           imm_i;
        logic [31:0]           imm_s;
        logic [31:0]           imm_u;
        logic [31:0]           val;
        logic                  flush;
        logic                  store;
        opc = word[6:0];
        f3 = word[14:12];
        imm_i = {{20{word[31]}}, word[31:20]};
        imm_s = {{20{word[31]}}, word[31:25], word[11:7]};
        imm_u = {word[31:12], 12'b0};
        flush = 1'b0;
        store = opc == `OPC_STORE;
        case (opc)
            `OPC_OPIMM: val = alu_model({f3 == 3'b101 && word[30], f3}, a, imm_i);
            `OPC_LOAD: val = a + imm_i;
            `OPC_JALR: begin
                val = a + imm_i;
                flush = 1'b1;
            end
            `OPC_STORE: val = a + imm_s;
            `OPC_BRANCH: begin
                val = pc + {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
                flush = branch_taken(f3, a, b);
            end
            `OPC_JAL: val = pc + {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
            `OPC_AUIPC: val = pc + imm_u;
            `OPC_LUI: val = imm_u;
            `OPC_SYSTEM: val = (f3 == `FUNCT3_CSRWI) ? {27'b0, word[19:15]} : a;
            default: val = alu_model({word[30], f3}, a, b);
        endcase
        r.alu_result = val;
        r.store_data = b;
        r.flush = valid && flush;
        r.dmem_we = valid && store && val[31:30] == 2'b00 && val[28];
        r.imem_we = valid && store && pc[30] && val[31:29] == 3'b001;
        r.uart_tx_valid = valid && store && val == `UART_TX_ADDR;
        r.uart_rx_ready = valid && opc == `OPC_LOAD && val == `UART_RX_ADDR;
        r.counters_reset = valid && store && val == `CNT_RESET_ADDR;
        return r;
    endfunction

    always @(posedge clk) begin
        checking <= 1'b1;
        if (rst) begin
            exp_valid <= 1'b0;
            exp_result <= '0;
            exp_cycle <= '0;
            exp_inst <= '0;
        end else begin
            exp_valid <= inst_valid;
            exp_result <= expect_result(inst_valid, inst, pc_xm, rs1_data, rs2_data);
            if (exp_result.counters_reset) begin
                exp_cycle <= '0;
                exp_inst <= '0;
            end else begin
                exp_cycle <= exp_cycle + 1;
                exp_inst <= exp_inst + (exp_valid ? 1 : 0);
            end
        end
    end

    task automatic report_mismatch(input string what, input logic [95:0] got,
                                   input logic [95:0] want);
        $display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, want);
        $display("SIMULATION FAILED");
        $fatal(1, "output check failed");
    endtask

    valid_check: assert property (@(posedge clk) checking |-> out_valid == exp_valid)
        else report_mismatch("out_valid", $sampled(out_valid), $sampled(exp_valid));
    result_check: assert property (@(posedge clk) checking |-> result == exp_result)
        else report_mismatch("result", $sampled(result), $sampled(exp_result));
    cycle_check: assert property (@(posedge clk) checking |-> cycle_count == exp_cycle)
        else report_mismatch("cycle_count", $sampled(cycle_count), $sampled(exp_cycle));
    inst_check: assert property (@(posedge clk) checking |-> inst_count == exp_inst)
        else report_mismatch("inst_count", $sampled(inst_count), $sampled(exp_inst));

    task automatic issue(input logic [31:0] word, input logic [31:0] pc,
                         input logic [31:0] a, input logic [31:0] b);
        @(posedge clk);
        inst_valid <= 1'b1;
        inst <= word;
        pc_xm <= pc;
        rs1_data <= a;
        rs2_data <= b;
        issued = issued + 1;
    endtask

    task automatic idle();
        @(posedge clk);
        inst_valid <= 1'b0;
    endtask

    initial begin
        #(TIMEOUT_CYCLES * 20);
        $display("simulation timed out at %0t before the tests finished", $time);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int          k;
        logic [31:0] pick;
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        logic [11:0] imm12;
        rst = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        pc_xm = '0;
        rs1_data = '0;
        rs2_data = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (k = 0; k < 8; k++) begin
            issue(r_format(7'h00, k[2:0]), 32'h100, 32'hf000_1234, 32'h0000_0013);
        end
        issue(r_format(7'h20, 3'b000), 32'h100, 32'h0000_0005, 32'h0000_0009);
        issue(r_format(7'h20, 3'b101), 32'h100, 32'h8000_0f00, 32'h0000_0004);
        idle();
        for (k = 0; k < 8; k++) begin
            imm12 = (k == 1 || k == 5) ? 12'h007 : 12'hf85;
            issue(i_format(imm12, k[2:0], 5'd1, `OPC_OPIMM), 32'h100, 32'h8123_4567, 32'h0);
        end
        issue(i_format(12'h405, 3'b101, 5'd1, `OPC_OPIMM), 32'h100, 32'hf000_0000, 32'h0);
        for (k = 0; k < 8; k++) begin
            if (k != 2 && k != 3) begin
                issue(b_format(13'h0040, k[2:0]), 32'h2000, 32'h0000_0005, 32'h0000_0005);
                issue(b_format(13'h1ff0, k[2:0]), 32'h2000, 32'hffff_fffd, 32'h0000_0007);
            end
        end
        issue(i_format(12'h010, 3'b000, 5'd1, `OPC_JALR), 32'h300, 32'h0000_1000, 32'h0);
        issue(j_format(21'h000800), 32'h300, 32'h0, 32'h0);
        issue({20'h12345, 5'd3, `OPC_LUI}, 32'h300, 32'h0, 32'h0);
        issue({20'h12345, 5'd3, `OPC_AUIPC}, 32'h300, 32'h0, 32'h0);
        issue(i_format(12'h300, `FUNCT3_CSRWI, 5'd19, `OPC_SYSTEM), 32'h300, 32'h77, 32'h0);
        issue(i_format(12'h300, 3'b001, 5'd1, `OPC_SYSTEM), 32'h300, 32'h77, 32'h0);
        idle();
        issue(s_format(12'h010, 3'b010), 32'h100, 32'h1000_0000, 32'hdead_beef);
        issue(s_format(12'h040, 3'b010), 32'h4000_0000, 32'h2000_0000, 32'h1111_2222);
        issue(s_format(12'h040, 3'b010), 32'h100, 32'h2000_0000, 32'h3333_4444);
        issue(s_format(12'h000, 3'b010), 32'h100, `UART_TX_ADDR, 32'h41);
        issue(i_format(12'h000, 3'b010, 5'd1, `OPC_LOAD), 32'h100, `UART_TX_ADDR, 32'h0);
        issue(i_format(12'h000, 3'b010, 5'd1, `OPC_LOAD), 32'h100, `UART_RX_ADDR, 32'h0);
        issue(i_format(12'h010, 3'b010, 5'd1, `OPC_LOAD), 32'h100, 32'h1000_0000, 32'h0);
        idle();
        idle();
        issue(s_format(12'h000, 3'b010), 32'h100, `CNT_RESET_ADDR, 32'h0);
        issued = 0;
        idle();
        issue(r_format(7'h00, 3'b000), 32'h100, 32'h1, 32'h2);
        issue(r_format(7'h00, 3'b110), 32'h100, 32'h4, 32'h8);
        repeat (NUM_RANDOM) begin
            pick = $random(seed);
            a = $random(seed);
            b = $random(seed);
            f3 = pick[4:2];
            case (pick[1:0])
                2'd0: idle();
                2'd1: issue(r_format((f3 == 3'b000 || f3 == 3'b101) && pick[5] ? 7'h20 : 7'h00,
                                     f3), a & ~32'h3, a, b);
                2'd2: begin
                    imm12 = pick[17:6];
                    if (f3 == 3'b001 || f3 == 3'b101) begin
                        imm12[11:5] = (f3 == 3'b101 && pick[5]) ? 7'h20 : 7'h00;
                    end
                    issue(i_format(imm12, f3, 5'd1, `OPC_OPIMM), a & ~32'h3, a, b);
                end
                default: begin
                    // equal operands on half of the branches so eq and ge get taken.
                    f3[1] = f3[2] & f3[1];
                    issue(b_format({pick[18:7], 1'b0}, f3), b & ~32'h3, a, pick[5] ? a : b);
                end
            endcase
        end
        repeat (3) idle();
        @(negedge clk);
        if (inst_count !== issued) begin
            report_mismatch("final inst_count", inst_count, issued);
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

/* common/riscv_defs.svh */
`ifndef RISCV_DEFS_SVH
`define RISCV_DEFS_SVH

`define XLEN 32

// memory-mapped I/O registers, one word each.
`define UART_RX_ADDR   32'h80000004
`define UART_TX_ADDR   32'h80000008
`define CNT_RESET_ADDR 32'h80000018

`define OPC_LOAD   7'b0000011
`define OPC_OPIMM  7'b0010011
`define OPC_AUIPC  7'b0010111
`define OPC_STORE  7'b0100011
`define OPC_OP     7'b0110011
`define OPC_LUI    7'b0110111
`define OPC_BRANCH 7'b1100011
`define OPC_JALR   7'b1100111
`define OPC_JAL    7'b1101111
`define OPC_SYSTEM 7'b1110011

`define FUNCT3_CSRWI 3'b101

`endif

/* common/riscv_pkg.sv */
`include "riscv_defs.svh"

package riscv_pkg;

    typedef enum logic [2:0] {
        R_TYPE = 3'd0,
        I_TYPE = 3'd1,
        S_TYPE = 3'd2,
        B_TYPE = 3'd3,
        U_TYPE = 3'd4,
        J_TYPE = 3'd5,
        C_TYPE = 3'd6
    } inst_type_e;

    // encoding is funct7 bit 5 followed by funct3, so R-format fields map straight across.
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0_000,
        ALU_SLL    = 4'b0_001,
        ALU_SLT    = 4'b0_010,
        ALU_SLTU   = 4'b0_011,
        ALU_XOR    = 4'b0_100,
        ALU_SRL    = 4'b0_101,
        ALU_OR     = 4'b0_110,
        ALU_AND    = 4'b0_111,
        ALU_SUB    = 4'b1_000,
        ALU_SRA    = 4'b1_101,
        ALU_PASS_B = 4'b1_110,
        ALU_PASS_A = 4'b1_111
    } alu_op_e;

    typedef enum logic {
        A_RS1 = 1'b0,
        A_PC  = 1'b1
    } a_sel_e;

    typedef enum logic {
        B_RS2 = 1'b0,
        B_IMM = 1'b1
    } b_sel_e;

    typedef struct packed {
        logic [6:0] opcode;
        logic [4:0] rd;
        logic [2:0] funct3;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [6:0] funct7;
        inst_type_e inst_type;
    } inst_fields_t;

    // flush already folds in the branch outcome and jalr.
    typedef struct packed {
        a_sel_e     a_sel;
        b_sel_e     b_sel;
        alu_op_e    alu_op;
        logic [2:0] br_sel;
        logic       is_branch;
        logic       flush;
        logic       dmem_we;
        logic       imem_we;
        logic       uart_tx_valid;
        logic       uart_rx_ready;
        logic       counters_reset;
    } xm_ctrl_t;

    typedef struct packed {
        logic [`XLEN-1:0] alu_result;
        logic [`XLEN-1:0] store_data;
        logic             flush;
        logic             dmem_we;
        logic             imem_we;
        logic             uart_tx_valid;
        logic             uart_rx_ready;
        logic             counters_reset;
    } xm_result_t;

endpackage

/* project.f */
+incdir+common
common/riscv_pkg.sv
source/inst_splitter.sv
source/imm_gen.sv
xm_stage/xm_logic.sv
xm_stage/alu.sv
xm_stage/xm_stage.sv
source/io_counters.sv
source/xm_top.sv
bench/xm_top_tb.sv

/* source/imm_gen.sv */
`include "riscv_defs.svh"

module imm_gen (
    input  logic [`XLEN-1:0]      inst,
    input  riscv_pkg::inst_type_e inst_type,
    output logic [`XLEN-1:0]      imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (inst_type)
            riscv_pkg::I_TYPE: begin
                imm = {{20{sign}}, inst[31:20]};
            end
            riscv_pkg::S_TYPE: begin
                imm = {{20{sign}}, inst[31:25], inst[11:7]};
            end
            // branch and jump offsets are in halfwords, so bit 0 is always zero.
            riscv_pkg::B_TYPE: begin
                imm = {{19{sign}}, sign, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            riscv_pkg::U_TYPE: begin
                imm = {inst[31:12], 12'b0};
            end
            riscv_pkg::J_TYPE: begin
                imm = {{11{sign}}, sign, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            // csrwi carries its 5-bit immediate in the rs1 slot.
            default: begin
                imm = {27'b0, inst[19:15]};
            end
        endcase
    end

endmodule

/* source/inst_splitter.sv */
`include "riscv_defs.svh"

module inst_splitter (
    input  logic [`XLEN-1:0]        inst,
    output riscv_pkg::inst_fields_t fields
);

    logic [6:0] opcode;

    assign opcode = inst[6:0];

    always_comb begin
        fields.opcode = opcode;
        fields.rd     = inst[11:7];
        fields.funct3 = inst[14:12];
        fields.rs1    = inst[19:15];
        fields.rs2    = inst[24:20];
        fields.funct7 = inst[31:25];

        case (opcode)
            `OPC_OP: begin
                fields.inst_type = riscv_pkg::R_TYPE;
            end
            `OPC_LOAD, `OPC_OPIMM, `OPC_JALR: begin
                fields.inst_type = riscv_pkg::I_TYPE;
            end
            `OPC_STORE: begin
                fields.inst_type = riscv_pkg::S_TYPE;
            end
            `OPC_BRANCH: begin
                fields.inst_type = riscv_pkg::B_TYPE;
            end
            `OPC_LUI, `OPC_AUIPC: begin
                fields.inst_type = riscv_pkg::U_TYPE;
            end
            `OPC_JAL: begin
                fields.inst_type = riscv_pkg::J_TYPE;
            end
            // CSR accesses all live under the system opcode.
            `OPC_SYSTEM: begin
                fields.inst_type = riscv_pkg::C_TYPE;
            end
            default: begin
                fields.inst_type = riscv_pkg::R_TYPE;
            end
        endcase
    end

endmodule

/* source/io_counters.sv */
`include "riscv_defs.svh"

module io_counters (
    input  logic             clk,
    input  logic             rst,
    input  logic             retire,
    input  logic             clear,
    output logic [`XLEN-1:0] cycle_count,
    output logic [`XLEN-1:0] inst_count
);

    // a clear wins over a retire landing in the same cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_count <= '0;
            inst_count  <= '0;
        end else if (clear) begin
            cycle_count <= '0;
            inst_count  <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
            if (retire) begin
                inst_count <= inst_count + 1'b1;
            end
        end
    end

    property p_clear_zeroes_counts;
        @(posedge clk) disable iff (rst)
        clear |=> (cycle_count == '0 && inst_count == '0);
    endproperty

    clear_zeroes_counts: assert property (p_clear_zeroes_counts)
        else $error("counters not zero after clear");

endmodule

/* source/xm_top.sv */
`include "riscv_defs.svh"

module xm_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_valid,
    input  logic [`XLEN-1:0]      inst,
    input  logic [`XLEN-1:0]      pc_xm,
    input  logic [`XLEN-1:0]      rs1_data,
    input  logic [`XLEN-1:0]      rs2_data,
    output logic                  out_valid,
    output riscv_pkg::xm_result_t result,
    output logic [`XLEN-1:0]      cycle_count,
    output logic [`XLEN-1:0]      inst_count
);

    riscv_pkg::xm_result_t stage_result;

    xm_stage u_stage (
        .inst_valid(inst_valid),
        .inst      (inst),
        .pc_xm     (pc_xm),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .result    (stage_result)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= inst_valid;
            result    <= stage_result;
        end
    end

    // counters act on the registered result, one cycle after the store is presented.
    io_counters u_counters (
        .clk        (clk),
        .rst        (rst),
        .retire     (out_valid),
        .clear      (result.counters_reset),
        .cycle_count(cycle_count),
        .inst_count (inst_count)
    );

    idle_outputs_quiet: assert property (
        @(posedge clk) disable iff (rst)
        !out_valid |-> !(result.flush || result.dmem_we || result.imem_we ||
                         result.uart_tx_valid || result.uart_rx_ready || result.counters_reset)
    ) else $error("strobe or flush raised without out_valid");

endmodule

/* xm_stage/alu.sv */
`include "riscv_defs.svh"

module alu (
    input  logic [`XLEN-1:0]   a,
    input  logic [`XLEN-1:0]   b,
    input  riscv_pkg::alu_op_e op,
    output logic [`XLEN-1:0]   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            riscv_pkg::ALU_ADD: begin
                result = a + b;
            end
            riscv_pkg::ALU_SUB: begin
                result = a - b;
            end
            riscv_pkg::ALU_AND: begin
                result = a & b;
            end
            riscv_pkg::ALU_OR: begin
                result = a | b;
            end
            riscv_pkg::ALU_XOR: begin
                result = a ^ b;
            end
            riscv_pkg::ALU_SLL: begin
                result = a << shamt;
            end
            riscv_pkg::ALU_SRL: begin
                result = a >> shamt;
            end
            riscv_pkg::ALU_SRA: begin
                result = $signed(a) >>> shamt;
            end
            riscv_pkg::ALU_SLT: begin
                result = {31'b0, $signed(a) < $signed(b)};
            end
            riscv_pkg::ALU_SLTU: begin
                result = {31'b0, a < b};
            end
            riscv_pkg::ALU_PASS_A: begin
                result = a;
            end
            default: begin
                result = b;
            end
        endcase
    end

endmodule

/* xm_stage/xm_logic.sv */
`include "riscv_defs.svh"

module xm_logic (
    input  riscv_pkg::inst_fields_t fields,
    input  logic [`XLEN-1:0]        pc_xm,
    input  logic [`XLEN-1:0]        addr,
    input  logic                    br_taken,
    output riscv_pkg::xm_ctrl_t     ctrl
);

    logic is_store;
    logic is_load;
    logic is_branch;
    logic is_jalr;
    logic is_srai;
    logic bios_mode;

    assign is_store  = fields.inst_type == riscv_pkg::S_TYPE;
    assign is_load   = fields.opcode == `OPC_LOAD;
    assign is_branch = fields.inst_type == riscv_pkg::B_TYPE;
    assign is_jalr   = fields.opcode == `OPC_JALR;
    assign is_srai   = fields.funct3 == 3'b101 && fields.funct7[5];

    // instruction memory is only writable while running from the boot ROM.
    assign bios_mode = pc_xm[30];

    always_comb begin
        ctrl.br_sel    = fields.funct3;
        ctrl.is_branch = is_branch;
        ctrl.flush     = is_branch ? br_taken : is_jalr;

        ctrl.dmem_we        = is_store && addr[31:30] == 2'b00 && addr[28];
        ctrl.imem_we        = is_store && bios_mode && addr[31:29] == 3'b001;
        ctrl.uart_tx_valid  = is_store && addr == `UART_TX_ADDR;
        ctrl.uart_rx_ready  = is_load && addr == `UART_RX_ADDR;
        ctrl.counters_reset = is_store && addr == `CNT_RESET_ADDR;

        case (fields.inst_type)
            riscv_pkg::R_TYPE: begin
                ctrl.a_sel  = riscv_pkg::A_RS1;
                ctrl.b_sel  = riscv_pkg::B_RS2;
                ctrl.alu_op = riscv_pkg::alu_op_e'({fields.funct7[5], fields.funct3});
            end
            riscv_pkg::I_TYPE: begin
                ctrl.a_sel = riscv_pkg::A_RS1;
                ctrl.b_sel = riscv_pkg::B_IMM;
                if (fields.opcode == `OPC_OPIMM) begin
                    ctrl.alu_op = riscv_pkg::alu_op_e'({is_srai, fields.funct3});
                end else begin
                    ctrl.alu_op = riscv_pkg::ALU_ADD;
                end
            end
            riscv_pkg::U_TYPE: begin
                ctrl.a_sel = riscv_pkg::A_PC;
                ctrl.b_sel = riscv_pkg::B_IMM;
                if (fields.opcode == `OPC_AUIPC) begin
                    ctrl.alu_op = riscv_pkg::ALU_ADD;
                end else begin
                    ctrl.alu_op = riscv_pkg::ALU_PASS_B;
                end
            end
            riscv_pkg::B_TYPE, riscv_pkg::J_TYPE: begin
                ctrl.a_sel  = riscv_pkg::A_PC;
                ctrl.b_sel  = riscv_pkg::B_IMM;
                ctrl.alu_op = riscv_pkg::ALU_ADD;
            end
            // csrwi forwards its immediate, csrw forwards rs1.
            riscv_pkg::C_TYPE: begin
                ctrl.a_sel = riscv_pkg::A_RS1;
                ctrl.b_sel = riscv_pkg::B_IMM;
                if (fields.funct3 == `FUNCT3_CSRWI) begin
                    ctrl.alu_op = riscv_pkg::ALU_PASS_B;
                end else begin
                    ctrl.alu_op = riscv_pkg::ALU_PASS_A;
                end
            end
            default: begin
                ctrl.a_sel  = riscv_pkg::A_RS1;
                ctrl.b_sel  = riscv_pkg::B_IMM;
                ctrl.alu_op = riscv_pkg::ALU_ADD;
            end
        endcase
    end

    // a store writes at most one memory or I/O register.
    store_target_unique: assert final ($onehot0({ctrl.dmem_we,
                                                ctrl.imem_we,
                                                ctrl.uart_tx_valid,
                                                ctrl.counters_reset}))
        else $error("store decoded to more than one target");

endmodule

/* xm_stage/xm_stage.sv */
`include "riscv_defs.svh"

module xm_stage (
    input  logic                  inst_valid,
    input  logic [`XLEN-1:0]      inst,
    input  logic [`XLEN-1:0]      pc_xm,
    input  logic [`XLEN-1:0]      rs1_data,
    input  logic [`XLEN-1:0]      rs2_data,
    output riscv_pkg::xm_result_t result
);

    riscv_pkg::inst_fields_t fields;
    riscv_pkg::xm_ctrl_t     ctrl;
    logic [`XLEN-1:0]        imm;
    logic [`XLEN-1:0]        alu_a;
    logic [`XLEN-1:0]        alu_b;
    logic [`XLEN-1:0]        alu_result;
    logic                    br_cond;
    logic                    br_taken;

    inst_splitter u_splitter (.inst(inst), .fields(fields));

    imm_gen u_imm_gen (.inst(inst), .inst_type(fields.inst_type), .imm(imm));

    // the ALU result doubles as the effective address for the memory map.
    xm_logic u_logic (
        .fields  (fields),
        .pc_xm   (pc_xm),
        .addr    (alu_result),
        .br_taken(br_taken),
        .ctrl    (ctrl)
    );

    assign alu_a = (ctrl.a_sel == riscv_pkg::A_PC) ? pc_xm : rs1_data;
    assign alu_b = (ctrl.b_sel == riscv_pkg::B_IMM) ? imm : rs2_data;

    alu u_alu (.a(alu_a), .b(alu_b), .op(ctrl.alu_op), .result(alu_result));

    always_comb begin
        case (ctrl.br_sel)
            3'b000:  br_cond = rs1_data == rs2_data;
            3'b001:  br_cond = rs1_data != rs2_data;
            3'b100:  br_cond = $signed(rs1_data) < $signed(rs2_data);
            3'b101:  br_cond = $signed(rs1_data) >= $signed(rs2_data);
            3'b110:  br_cond = rs1_data < rs2_data;
            3'b111:  br_cond = rs1_data >= rs2_data;
            default: br_cond = 1'b0;
        endcase
    end

    assign br_taken = ctrl.is_branch && br_cond;

    always_comb begin
        result.alu_result     = alu_result;
        result.store_data     = rs2_data;
        result.flush          = inst_valid && ctrl.flush;
        result.dmem_we        = inst_valid && ctrl.dmem_we;
        result.imem_we        = inst_valid && ctrl.imem_we;
        result.uart_tx_valid  = inst_valid && ctrl.uart_tx_valid;
        result.uart_rx_ready  = inst_valid && ctrl.uart_rx_ready;
        result.counters_reset = inst_valid && ctrl.counters_reset;
    end

endmodule
